// File: cart_loader_top.f
+incdir+logic
logic/cart_loader_pkg.sv
logic/download_router.sv
logic/bios_byte_splitter.sv
logic/cheat_code_assembler.sv
logic/cart_mem_arbiter.sv
logic/cart_loader_top.sv
bench/clk_rst_gen.sv
bench/cart_loader_assert.sv
bench/cart_loader_tb.sv

// File: Bender.yml
package:
  name: cart_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/cart_loader_pkg.sv
      - logic/download_router.sv
      - logic/bios_byte_splitter.sv
      - logic/cheat_code_assembler.sv
      - logic/cart_mem_arbiter.sv
      - logic/cart_loader_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/clk_rst_gen.sv
      - bench/cart_loader_assert.sv
      - bench/cart_loader_tb.sv

// File: bench/cart_loader_tb.sv
// Needs the default 12-bit cartridge build; reads only target words written earlier in the run
`include "cart_loader_config.svh"

module cart_loader_tb
	import cart_loader_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_NS = 20;
	localparam int N_CART = 48; // Words per cartridge download
	localparam int N_READ = 40; // Reads per read test
	// Cycle estimate summed over all tests
	localparam int CYC_TOTAL = 8 + N_CART * 5 + 4 + N_READ * 5 + N_CART * 5 + N_READ * 8 + 12 + 26;

	logic                    clk_sys;
	logic                    arst_n;
	logic                    dl_active;
	filetype_e               dl_filetype;
	logic                    dl_wr;
	logic [`DL_ADDR_W-1:0]   dl_addr;
	logic [15:0]             dl_data;
	logic                    rom_req;
	logic [`CART_ADDR_W-1:0] rom_addr;
	logic                    dl_wait;
	logic                    cart_ready;
	logic [`DL_ADDR_W-1:0]   cart_size;
	logic                    rom_ack;
	logic [7:0]              rom_byte;
	logic                    bios_wr;
	logic [`BIOS_ADDR_W-1:0] bios_addr;
	logic [7:0]              bios_data;
	logic                    cheat_valid;
	logic                    cheat_clear;
	cheat_code_u             cheat_code;

	logic [15:0] shadow [`CART_WORDS]; // Words as the host sent them
	int          done_words[$];        // Word indexes whose write completed
	string       cur_test = "reset";
	int          errors = 0;
	int          err_mark = 0;
	int          n_checks = 0;
	int          n_tests = 0;
	int          reads_seen = 0;
	int          clear_seen = 0;
	int          valid_seen = 0;

	clk_rst_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) u_clk (.clk_sys, .arst_n);

	cart_loader_top u_dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// Reference, checker and bookkeeping
	////////////////////////////////////////////////////////////////////////////

	// Odd byte address is the upper half of its word
	function automatic logic [7:0] ref_byte(input logic [`CART_ADDR_W-1:0] addr);
		logic [15:0] word;
		word = shadow[addr >> 1];
		return addr[0] ? word[15:8] : word[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (expected !== actual) begin
			$display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic open_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic close_test();
		n_tests++;
		if (errors == err_mark) begin
			$display("%-22s ok", cur_test);
		end else begin
			$display("%-22s %0d errors", cur_test, errors - err_mark);
		end
	endtask

	// Compares every returned byte and counts the one-cycle pulses
	always @(negedge clk_sys) begin
		if (arst_n) begin
			if (rom_ack) begin
				check_value({cur_test, " rom_byte"}, ref_byte(rom_addr), rom_byte);
				reads_seen++;
			end
			clear_seen += cheat_clear;
			valid_seen += cheat_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host and read port drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic cart_write(input int word, input logic [15:0] data);
		shadow[word] = data;
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= 16'(word * 2);
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		@(negedge clk_sys);
		check_value({cur_test, " dl_wait"}, 1, dl_wait); // Host must be held
		while (dl_wait)
			@(negedge clk_sys);
		done_words.push_back(word);
	endtask

	task automatic cart_download(input int first, input int count, input filetype_e ft);
		@(posedge clk_sys);
		dl_active   <= 1'b1;
		dl_filetype <= ft;
		for (int i = 0; i < count; i++)
			cart_write(first + i, 16'($urandom));
		@(posedge clk_sys);
		dl_active <= 1'b0;
	endtask

	task automatic rom_read(input logic [`CART_ADDR_W-1:0] addr);
		@(posedge clk_sys);
		rom_req  <= 1'b1;
		rom_addr <= addr;
		@(negedge clk_sys);
		while (!rom_ack)
			@(negedge clk_sys);
		@(posedge clk_sys);
		rom_req <= 1'b0;
	endtask

	task automatic read_random_bytes(input int count);
		int w;
		int mark;
		mark = reads_seen;
		repeat (count) begin
			w = done_words[$urandom_range(done_words.size() - 1)];
			rom_read({w[`CART_ADDR_W-2:0], 1'($urandom)});
		end
		check_value({cur_test, " read count"}, count, reads_seen - mark);
	endtask

	task automatic split_bios_word();
		logic [15:0] addr;
		logic [15:0] data;
		addr = 16'($urandom);
		data = 16'($urandom);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		@(negedge clk_sys);
		check_value("bios low bios_wr", 1, bios_wr);
		check_value("bios low bios_addr", addr[`BIOS_ADDR_W-1:0], bios_addr);
		check_value("bios low bios_data", data[7:0], bios_data);
		@(negedge clk_sys);
		check_value("bios high bios_wr", 1, bios_wr);
		check_value("bios high bios_addr", `BIOS_ADDR_W'(addr + 1), bios_addr);
		check_value("bios high bios_data", data[15:8], bios_data);
		@(negedge clk_sys);
		check_value("bios end bios_wr", 0, bios_wr);
	endtask

	task automatic load_cheat_code();
		logic [15:0] half [8];
		int          clear_mark;
		int          valid_mark;
		clear_mark = clear_seen;
		valid_mark = valid_seen;
		@(posedge clk_sys);
		dl_active   <= 1'b1;
		dl_filetype <= ft_cheat;
		for (int k = 0; k < 8; k++) begin
			half[k] = 16'($urandom);
			@(posedge clk_sys);
			dl_wr   <= 1'b1;
			dl_addr <= 16'(2 * k); // Offset 14 goes last
			dl_data <= half[k];
			@(posedge clk_sys);
			dl_wr <= 1'b0;
		end
		@(negedge clk_sys);
		while (!cheat_valid)
			@(negedge clk_sys);
		// Each field takes two halfwords, low half first
		check_value("cheat flags", {half[1], half[0]}, cheat_code.fields.flags);
		check_value("cheat address", {half[3], half[2]}, cheat_code.fields.address);
		check_value("cheat compare", {half[5], half[4]}, cheat_code.fields.compare);
		check_value("cheat replace", {half[7], half[6]}, cheat_code.fields.replace);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		@(negedge clk_sys);
		check_value("cheat clear pulses", 1, clear_seen - clear_mark);
		check_value("cheat valid pulses", 1, valid_seen - valid_mark);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		dl_active   = 1'b0;
		dl_filetype = ft_bios;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		rom_req     = 1'b0;
		rom_addr    = '0;
		void'($urandom(32'h65de_06ce));
		wait (arst_n === 1'b1);
		@(negedge clk_sys);
		open_test("reset_state");
		check_value("reset dl_wait", 0, dl_wait);
		check_value("reset rom_ack", 0, rom_ack);
		check_value("reset bios_wr", 0, bios_wr);
		check_value("reset cheat_valid", 0, cheat_valid);
		check_value("reset cheat_clear", 0, cheat_clear);
		check_value("reset cart_ready", 0, cart_ready);
		close_test();
		open_test("cart_download");
		cart_download(0, N_CART, ft_cart_a);
		close_test();
		open_test("cart_ready");
		@(negedge clk_sys);
		check_value("cart_ready early", 0, cart_ready); // Download end still in flight
		@(negedge clk_sys);
		check_value("cart_ready", 1, cart_ready);
		check_value("cart_size", 2 * (N_CART - 1), cart_size);
		close_test();
		open_test("read_back");
		read_random_bytes(N_READ);
		close_test();
		open_test("read_during_download");
		fork
			cart_download(N_CART, N_CART, ft_cart_c);
			read_random_bytes(N_READ);
		join
		close_test();
		open_test("bios_split");
		@(posedge clk_sys);
		dl_active   <= 1'b1;
		dl_filetype <= ft_bios;
		repeat (2) split_bios_word();
		@(posedge clk_sys);
		dl_active <= 1'b0;
		close_test();
		open_test("cheat_code");
		load_cheat_code();
		close_test();
		errors += u_dut.u_arb.u_assert.fail_count;
		$display("tests %0d, checks %0d, assertion failures %0d, errors %0d", n_tests,
			n_checks, u_dut.u_arb.u_assert.fail_count, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(2 * CYC_TOTAL * CLK_NS);
		$display("timeout: tests still running after %0d cycles", 2 * CYC_TOTAL);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: bench/cart_loader_assert.sv
// Bound into cart_mem_arbiter; every check is disabled while arst_n is low
module cart_loader_assert (
	input logic clk_sys,
	input logic arst_n,
	input logic wr_req,
	input logic rom_req,
	input logic wr_ack,
	input logic rom_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0; // Failed assertions so far

	// One item in flight, so the acks never overlap
	ack_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(wr_ack && rom_ack))
	else begin
		fail_count++;
		$error("wr_ack and rom_ack are high in the same cycle");
	end

	wr_ack_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_ack |=> !wr_ack)
	else begin
		fail_count++;
		$error("wr_ack stayed high for more than one cycle");
	end

	rom_ack_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_ack |=> !rom_ack)
	else begin
		fail_count++;
		$error("rom_ack stayed high for more than one cycle");
	end

	wr_ack_after_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_ack |-> $past(wr_req))
	else begin
		fail_count++;
		$error("wr_ack without a preceding wr_req");
	end

	rom_ack_after_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_ack |-> $past(rom_req))
	else begin
		fail_count++;
		$error("rom_ack without a preceding rom_req");
	end

endmodule

bind cart_mem_arbiter cart_loader_assert u_assert (.*);

// File: bench/clk_rst_gen.sv
// Free-running clock from time zero; reset is released on a falling edge after RST_CYCLES rising edges
module clk_rst_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 2
) (
	output logic clk_sys,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1; // Away from the active edge
	end

endmodule

// File: logic/cart_loader_top.sv
// Cartridge reads share the memory with downloads and wait while a cartridge write is pending
`include "cart_loader_config.svh"

module cart_loader_top
	import cart_loader_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    dl_active,
	input  filetype_e               dl_filetype,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	input  logic                    rom_req,
	input  logic [`CART_ADDR_W-1:0] rom_addr,
	output logic                    dl_wait,
	output logic                    cart_ready,
	output logic [`DL_ADDR_W-1:0]   cart_size,
	output logic                    rom_ack,
	output logic [7:0]              rom_byte,
	output logic                    bios_wr,
	output logic [`BIOS_ADDR_W-1:0] bios_addr,
	output logic [7:0]              bios_data,
	output logic                    cheat_valid,
	output logic                    cheat_clear,
	output cheat_code_u             cheat_code
);

	// Router to arbiter write channel
	logic                    wr_req;
	logic [`CART_ADDR_W-2:0] wr_addr;
	logic [15:0]             wr_data;
	logic                    wr_ack;
	logic                    bios_sel;
	logic                    cheat_sel;

	download_router u_router (
		.clk_sys, .arst_n, .dl_active, .dl_filetype, .dl_wr, .dl_addr, .dl_data,
		.wr_ack, .dl_wait, .wr_req, .wr_addr, .wr_data, .cart_ready, .cart_size,
		.bios_sel, .cheat_sel
	);

	bios_byte_splitter u_bios (
		.clk_sys, .arst_n, .bios_sel, .dl_addr, .dl_data,
		.bios_wr, .bios_addr, .bios_data
	);

	cheat_code_assembler u_cheat (
		.clk_sys, .arst_n, .dl_active, .dl_filetype, .cheat_sel, .dl_addr, .dl_data,
		.cheat_valid, .cheat_clear, .cheat_code
	);

	cart_mem_arbiter u_arb (
		.clk_sys, .arst_n, .wr_req, .wr_addr, .wr_data, .rom_req, .rom_addr,
		.wr_ack, .rom_ack, .rom_byte
	);

endmodule

// File: logic/cart_mem_arbiter.sv
// Requesters drop their request on the edge that shows the ack; read data is valid only with rom_ack
`include "cart_loader_config.svh"

module cart_mem_arbiter (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    wr_req,
	input  logic [`CART_ADDR_W-2:0] wr_addr,
	input  logic [15:0]             wr_data,
	input  logic                    rom_req,
	input  logic [`CART_ADDR_W-1:0] rom_addr,
	output logic                    wr_ack,
	output logic                    rom_ack,
	output logic [7:0]              rom_byte
);

	logic [15:0] mem [`CART_WORDS];
	logic        rd_pend;  // Registered read request
	logic        busy;
	logic        grant_wr;
	logic        grant_rd;
	logic [15:0] rd_word;
	logic        rd_lsb;

	////////////////////////////////////////////////////////////////////////////
	// Fixed-priority grant
	////////////////////////////////////////////////////////////////////////////

	// Ack cycle still belongs to the last item
	assign busy     = wr_ack | rom_ack;
	assign grant_wr = wr_req & ~busy; // Writes always win
	assign grant_rd = rd_pend & ~wr_req & ~busy;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_pend <= 1'b0;
			wr_ack  <= 1'b0;
			rom_ack <= 1'b0;
		end else begin
			// Cleared once granted so a held rom_req is not served twice
			rd_pend <= rom_req & ~rom_ack & ~grant_rd;
			wr_ack  <= grant_wr;
			rom_ack <= grant_rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word memory, one cycle latency
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (grant_wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (grant_rd) begin
			rd_word <= mem[rom_addr[`CART_ADDR_W-1:1]];
			rd_lsb  <= rom_addr[0];
		end
	end

	// Odd address takes the high byte
	assign rom_byte = rd_lsb ? rd_word[15:8] : rd_word[7:0];

endmodule

// File: logic/cheat_code_assembler.sv
// Halfwords of one code may come in any order; valid fires on byte offset 14, so it must be last
`include "cart_loader_config.svh"

module cheat_code_assembler
	import cart_loader_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  dl_active,
	input  filetype_e             dl_filetype,
	input  logic                  cheat_sel,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]           dl_data,
	output logic                  cheat_valid,
	output logic                  cheat_clear,
	output cheat_code_u           cheat_code
);

	logic       active_q;
	logic [2:0] slot;

	// 2 * (3 - offset[3:2]) + offset[1], so each field lands low half first
	assign slot = {~dl_addr[3:2], dl_addr[1]};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q    <= 1'b0;
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			active_q    <= dl_active;
			// New cheat file drops the old codes
			cheat_clear <= dl_active & ~active_q & (dl_filetype == ft_cheat);
			cheat_valid <= cheat_sel & (dl_addr[3:1] == 3'd7); // Replace top half
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cheat_sel) begin
			cheat_code.halves[slot] <= dl_data;
		end
	end

endmodule

// File: logic/bios_byte_splitter.sv
// Boot-ROM words must arrive at least two cycles apart; the high byte goes to the address plus one
`include "cart_loader_config.svh"

module bios_byte_splitter (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    bios_sel,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	output logic                    bios_wr,
	output logic [`BIOS_ADDR_W-1:0] bios_addr,
	output logic [7:0]              bios_data
);

	logic       hi_pend; // High byte still to go
	logic [7:0] hi_byte;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bios_wr <= 1'b0;
			hi_pend <= 1'b0;
		end else begin
			bios_wr <= bios_sel | hi_pend;
			hi_pend <= bios_sel;
		end
	end

	// Low byte first, then the held high byte
	always_ff @(posedge clk_sys) begin
		if (bios_sel) begin
			bios_data <= dl_data[7:0];
			hi_byte   <= dl_data[15:8];
			bios_addr <= dl_addr[`BIOS_ADDR_W-1:0];
		end else if (hi_pend) begin
			bios_data <= hi_byte;
			bios_addr <= bios_addr + 1'b1;
		end
	end

endmodule

// File: logic/download_router.sv
// Host must not pulse dl_wr while dl_wait is high; cart_size is the byte address of the last write
`include "cart_loader_config.svh"

module download_router
	import cart_loader_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    dl_active,
	input  filetype_e               dl_filetype,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	input  logic                    wr_ack,
	output logic                    dl_wait,
	output logic                    wr_req,
	output logic [`CART_ADDR_W-2:0] wr_addr,
	output logic [15:0]             wr_data,
	output logic                    cart_ready,
	output logic [`DL_ADDR_W-1:0]   cart_size,
	output logic                    bios_sel,
	output logic                    cheat_sel
);

	logic                  is_cart;
	logic                  cart_dl;
	logic                  cart_dl_q; // Previous cycle of cart_dl
	logic [`DL_ADDR_W-1:0] last_addr;

	// All three cartridge flavours go to the same memory
	assign is_cart = (dl_filetype == ft_cart_a) || (dl_filetype == ft_cart_b) ||
		(dl_filetype == ft_cart_c);
	assign cart_dl   = dl_active & is_cart;
	assign bios_sel  = dl_active & dl_wr & (dl_filetype == ft_bios);
	assign cheat_sel = dl_active & dl_wr & (dl_filetype == ft_cheat);
	assign dl_wait   = wr_req; // Host held exactly while a write is pending

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_req     <= 1'b0;
			cart_dl_q  <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
			if (cart_dl && dl_wr) begin
				wr_req <= 1'b1;
			end else if (wr_ack) begin
				wr_req <= 1'b0;
			end
			// End of a cartridge download
			if (cart_dl_q && !cart_dl) begin
				cart_ready <= 1'b1; // Sticky until reset
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_dl && dl_wr) begin
			wr_addr   <= dl_addr[`CART_ADDR_W-1:1]; // Word address
			wr_data   <= dl_data;
			last_addr <= dl_addr;
		end
		if (cart_dl_q && !cart_dl) begin
			cart_size <= last_addr;
		end
	end

endmodule

// File: logic/cart_loader_pkg.sv
// Enum values follow the config header codes; a host tag outside them decodes to no target
`include "cart_loader_config.svh"

package cart_loader_pkg;

	// Download file types as tagged by the host
	typedef enum logic [7:0] {
		ft_bios   = `FT_BIOS,
		ft_cart_a = `FT_CART_A,
		ft_cart_b = `FT_CART_B,
		ft_cart_c = `FT_CART_C,
		ft_cheat  = `FT_CHEAT
	} filetype_e;

	// Cheat code fields, top bits first
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_s;

	// Loader fills halfwords, the console consumes fields
	typedef union packed {
		cheat_fields_s    fields;
		logic [7:0][15:0] halves; // Index 0 is bits 15:0
	} cheat_code_u;

endpackage

// File: logic/cart_loader_config.svh
// Default build holds a 4 KiB cartridge and a 512-byte boot ROM; file-type codes must stay distinct
`ifndef CART_LOADER_CONFIG_SVH
`define CART_LOADER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Address widths and memory depth
////////////////////////////////////////////////////////////////////////////
`define CART_ADDR_W 12 // Cartridge byte address
`define DL_ADDR_W   16 // Host download byte address
`define BIOS_ADDR_W 9  // Boot ROM byte address
`define CART_WORDS  (1 << (`CART_ADDR_W - 1)) // 16-bit words in the cartridge memory

// Host file-type tags
`define FT_BIOS   8'h00
`define FT_CART_A 8'h01
`define FT_CART_B 8'h41
`define FT_CART_C 8'h80
`define FT_CHEAT  8'hFF

`endif
